/* message.hex */
// one character per line in hex, 04 ends the message
48
69
20
74
68
65
72
65
04

/* stim_input.txt */
# T ends a test, B/F hh receive byte hh with a good/bad stop bit, R n receive n random bytes
# M n play the message (n = 1 also pulses play_capture meanwhile), C play the capture, E n count
M 0
E 0
T
B 41
B 62
F 55
R 20
E 22
T
C
E 0
C
E 0
T
B 33
M 1
E 1
C
E 0
T

/* tb.f */
playback_pkg.sv
uart_rx.sv
uart_tx.sv
message_rom.sv
capture_buffer.sv
playback_ctrl.sv
text_playback_top.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "ALL TESTS PASSED" sim.log

/* tb_top.sv */
// text playback testbench
// runs the test program in stim_input.txt, drives the serial input and
// the command pulses, and hands expected bytes to the checker
`timescale 1ns/1ps

module tb_top;

    localparam int CPB   = playback_pkg::CLKS_PER_BIT;
    localparam int FRAME = playback_pkg::FRAME_BITS * CPB;  // cycles per frame

    logic                            CLK100MHZ = 1'b0;
    logic                            rst, rxd, play_msg, play_capture;
    logic                            txd, tx_busy, rx_busy;
    logic [playback_pkg::CNT_W-1:0]  bytes_loaded;
    logic                            exp_push, cnt_check, idle_check, busy_check;
    logic [playback_pkg::DATA_W-1:0] exp_byte;
    logic [playback_pkg::CNT_W-1:0]  exp_count;
    int                              errors, pending;

    logic [playback_pkg::DATA_W-1:0] msg_mem [playback_pkg::MSG_DEPTH];
    logic [playback_pkg::DATA_W-1:0] msg_q[$];
    logic [playback_pkg::DATA_W-1:0] cap_q[$];  // model of the capture buffer
    int unsigned                     lcg_state = 32'd81092;
    int                              test_num = 0, pass_cnt = 0, fail_cnt = 0;
    int                              err_base = 0, problems = 0;

    always #5 CLK100MHZ = ~CLK100MHZ;

    text_playback_top dut0 (.*);
    tb_checker chk0 (.*);

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_cycle();
        @(posedge CLK100MHZ);
        #1;
    endtask

    task automatic note_problem(input string what);
        $display("at %0t: %s", $time, what);
        problems++;
    endtask

    task automatic push_expected(input logic [7:0] b);
        exp_byte = b;
        exp_push = 1'b1;
        next_cycle();
        exp_push = 1'b0;
    endtask

    task automatic check_count(input int n);
        exp_count = playback_pkg::CNT_W'(n);
        cnt_check = 1'b1;
        next_cycle();
        cnt_check = 1'b0;
    endtask

    task automatic hold_quiet(input int cycles);
        idle_check = 1'b1;
        repeat (cycles) next_cycle();
        idle_check = 1'b0;
    endtask

    task automatic hold_rx_bit(input logic v);
        rxd = v;
        repeat (CPB) next_cycle();
    endtask

    task automatic send_rx_byte(input logic [7:0] b, input logic good_stop);
        int t;
        t = 0;
        hold_rx_bit(1'b0);
        busy_check = 1'b1;  // receiver has taken the start bit by now
        for (int i = 0; i < 8; i++) hold_rx_bit(b[i]);
        busy_check = 1'b0;
        hold_rx_bit(good_stop);
        rxd = 1'b1;
        while (rx_busy && t < 4 * CPB) begin
            next_cycle();
            t++;
        end
        if (rx_busy) note_problem("timeout waiting for the receiver to finish a byte");
        next_cycle();
        if (good_stop && cap_q.size() < playback_pkg::CAP_DEPTH) cap_q.push_back(b);
    endtask

    // waits for every expected byte to go out and then watches the line stay quiet
    task automatic wait_playback_end(input int n_bytes);
        int t;
        t = 0;
        while ((pending != 0 || tx_busy) && t < (n_bytes + 2) * (FRAME + CPB)) begin
            next_cycle();
            t++;
        end
        if (pending != 0 || tx_busy) note_problem("timeout waiting for playback to end");
        hold_quiet(3 * CPB);
    endtask

    task automatic play_message(input int with_capture);
        int t;
        t = 0;
        foreach (msg_q[i]) push_expected(msg_q[i]);
        play_msg = 1'b1;
        next_cycle();
        play_msg = 1'b0;
        if (with_capture != 0) begin
            while (!tx_busy && t < 8 * CPB) begin
                next_cycle();
                t++;
            end
            if (!tx_busy) note_problem("timeout waiting for the message to start");
            play_capture = 1'b1;  // the controller is busy and ignores this pulse
            next_cycle();
            play_capture = 1'b0;
        end
        wait_playback_end(msg_q.size());
    endtask

    task automatic play_captured();
        int n;
        n = cap_q.size();
        foreach (cap_q[i]) push_expected(cap_q[i]);
        cap_q.delete();  // replay empties the buffer
        play_capture = 1'b1;
        next_cycle();
        play_capture = 1'b0;
        wait_playback_end(n);
    endtask

    task automatic close_test();
        test_num++;
        if (errors != err_base || problems != 0) begin
            $display("test %0d failed", test_num);
            fail_cnt++;
        end else begin
            $display("test %0d passed", test_num);
            pass_cnt++;
        end
        err_base = errors;
        problems = 0;
    endtask

    initial begin
        int    fd;
        int    n;
        int    val;
        byte   kind;
        logic  needs_val;
        string line;
        rst          = 1'b1;
        rxd          = 1'b1;
        play_msg     = 1'b0;
        play_capture = 1'b0;
        exp_push     = 1'b0;
        exp_byte     = '0;
        cnt_check    = 1'b0;
        exp_count    = '0;
        idle_check   = 1'b0;
        busy_check   = 1'b0;
        for (int i = 0; i < playback_pkg::MSG_DEPTH; i++) msg_mem[i] = 8'h80 | 8'(i);
        $readmemh("message.hex", msg_mem);
        for (int i = 0; i < playback_pkg::MSG_DEPTH; i++) begin
            if (msg_mem[i] == playback_pkg::STOP_CHAR) break;
            msg_q.push_back(msg_mem[i]);
        end
        repeat (2) @(posedge CLK100MHZ);
        #1;
        rst = 1'b0;
        check_count(0);  // state right after reset
        hold_quiet(4 * CPB);
        close_test();
        fd = $fopen("stim_input.txt", "r");
        if (fd == 0) begin
            $display("could not open stim_input.txt");
            fail_cnt++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            kind = line[0];
            if (kind == "B" || kind == "F") n = $sscanf(line, "%c %h", kind, val);
            else n = $sscanf(line, "%c %d", kind, val);
            needs_val = (kind == "B" || kind == "F" || kind == "R" ||
                         kind == "M" || kind == "E");
            if (needs_val && n != 2) begin
                note_problem("stimulus line is missing its value");
            end else begin
                case (kind)
                    "B": send_rx_byte(8'(val), 1'b1);
                    "F": send_rx_byte(8'(val), 1'b0);
                    "R": begin
                        repeat (val) begin
                            lcg_state = lcg_next(lcg_state);
                            send_rx_byte(lcg_state[23:16], 1'b1);
                        end
                    end
                    "M": play_message(val);
                    "C": play_captured();
                    "E": check_count(val);
                    "T": close_test();
                    "#", "\n", "\r": ;
                    default: note_problem("stimulus line of unknown kind");
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        $display("%0d tests, %0d passed, %0d failed, %0d checker errors",
                 test_num, pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0 && problems == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb_checker.sv */
// serial output checker
// rebuilds frames on txd at the bit centres and compares them with the
// expected bytes, and compares the byte count, the idle lines and the
// receiver busy flag on request
`timescale 1ns/1ps

module tb_checker (
    input  logic                              CLK100MHZ,
    input  logic                              rst,
    input  logic                              txd,
    input  logic                              tx_busy,
    input  logic                              rx_busy,
    input  logic [playback_pkg::CNT_W-1:0]    bytes_loaded,
    input  logic                              exp_push,
    input  logic [playback_pkg::DATA_W-1:0]   exp_byte,
    input  logic                              cnt_check,
    input  logic [playback_pkg::CNT_W-1:0]    exp_count,
    input  logic                              idle_check,
    input  logic                              busy_check,
    output int                                errors,
    output int                                pending
);

    localparam int CPB = playback_pkg::CLKS_PER_BIT;

    logic [playback_pkg::DATA_W-1:0] expected_q[$];
    logic [playback_pkg::DATA_W-1:0] got;
    logic                            in_frame = 1'b0;
    int                              tick = 0;
    int                              bit_no;
    int                              err_cnt = 0;

    task automatic compare_frame(input logic stop_bit);
        logic [playback_pkg::DATA_W-1:0] want;
        if (stop_bit !== 1'b1) begin
            $display("ERROR at %0t: txd stop bit expected 1 got %b", $time, stop_bit);
            err_cnt++;
        end
        if (expected_q.size() == 0) begin
            $display("at %0t an unexpected byte %h went out on txd", $time, got);
            err_cnt++;
        end else begin
            want = expected_q.pop_front();
            if (got !== want) begin
                $display("ERROR at %0t: txd byte expected %h got %h", $time, want, got);
                err_cnt++;
            end
        end
    endtask

    // sampled on the falling edge away from the DUT's rising-edge updates
    always @(negedge CLK100MHZ) begin
        if (exp_push) expected_q.push_back(exp_byte);
        if (cnt_check && bytes_loaded !== exp_count) begin
            $display("ERROR at %0t: bytes_loaded expected %0d got %0d",
                     $time, exp_count, bytes_loaded);
            err_cnt++;
        end
        if (idle_check && txd !== 1'b1) begin
            $display("ERROR at %0t: txd expected 1 got %b", $time, txd);
            err_cnt++;
        end
        if (idle_check && tx_busy !== 1'b0) begin
            $display("ERROR at %0t: tx_busy expected 0 got %b", $time, tx_busy);
            err_cnt++;
        end
        if (idle_check && rx_busy !== 1'b0) begin
            $display("ERROR at %0t: rx_busy expected 0 got %b", $time, rx_busy);
            err_cnt++;
        end
        if (busy_check && rx_busy !== 1'b1) begin
            $display("ERROR at %0t: rx_busy expected 1 got %b", $time, rx_busy);
            err_cnt++;
        end
        if (rst) begin
            in_frame = 1'b0;
        end else if (!in_frame) begin
            if (txd === 1'b0) begin
                in_frame = 1'b1;  // start edge seen
                tick     = 0;
            end
        end else begin
            tick++;
            if (tick % CPB == CPB / 2) begin
                bit_no = tick / CPB;
                if (bit_no == 0 && txd !== 1'b0) begin
                    $display("at %0t a low pulse on txd was too short for a start bit", $time);
                    err_cnt++;
                    in_frame = 1'b0;
                end else if (bit_no >= 1 && bit_no <= playback_pkg::DATA_W) begin
                    got[bit_no-1] = txd;  // lsb first
                end else if (bit_no > playback_pkg::DATA_W) begin
                    in_frame = 1'b0;
                    compare_frame(txd);
                end
            end
        end
        errors  = err_cnt;
        pending = expected_q.size();
    end

endmodule

/* text_playback_top.sv */
// text playback top level
// message ROM and capture buffer side by side,
// the playback controller sends either one over the serial line
`timescale 1ns/1ps

module text_playback_top (
    input  logic                              CLK100MHZ,
    input  logic                              rst,
    input  logic                              rxd,
    input  logic                              play_msg,
    input  logic                              play_capture,
    output logic                              txd,
    output logic                              tx_busy,
    output logic                              rx_busy,
    output logic [playback_pkg::CNT_W-1:0]    bytes_loaded
);

    logic [playback_pkg::MSG_AW-1:0] msg_addr;
    logic [playback_pkg::DATA_W-1:0] msg_byte;
    logic [playback_pkg::CAP_AW-1:0] cap_addr;
    logic [playback_pkg::DATA_W-1:0] cap_byte;
    logic                            cap_clear;

    message_rom u_msg_rom (
        .CLK100MHZ (CLK100MHZ),
        .msg_addr  (msg_addr),
        .msg_byte  (msg_byte)
    );

    capture_buffer u_cap_buf (
        .CLK100MHZ (CLK100MHZ),
        .rst       (rst),
        .rxd       (rxd),
        .cap_addr  (cap_addr),
        .cap_clear (cap_clear),
        .cap_byte  (cap_byte),
        .cap_count (bytes_loaded),  // count goes straight out
        .rx_busy   (rx_busy)
    );

    playback_ctrl u_ctrl (
        .CLK100MHZ    (CLK100MHZ),
        .rst          (rst),
        .play_msg     (play_msg),
        .play_capture (play_capture),
        .msg_byte     (msg_byte),
        .cap_byte     (cap_byte),
        .cap_count    (bytes_loaded),
        .msg_addr     (msg_addr),
        .cap_addr     (cap_addr),
        .cap_clear    (cap_clear),
        .txd          (txd),
        .tx_busy      (tx_busy)
    );

endmodule

/* playback_ctrl.sv */
// playback controller
// walks the message ROM up to the stop character or the capture buffer
// up to its count and feeds each byte to the serial transmitter
`timescale 1ns/1ps

module playback_ctrl (
    input  logic                              CLK100MHZ,
    input  logic                              rst,
    input  logic                              play_msg,
    input  logic                              play_capture,
    input  logic [playback_pkg::DATA_W-1:0]   msg_byte,
    input  logic [playback_pkg::DATA_W-1:0]   cap_byte,
    input  logic [playback_pkg::CNT_W-1:0]    cap_count,
    output logic [playback_pkg::MSG_AW-1:0]   msg_addr,
    output logic [playback_pkg::CAP_AW-1:0]   cap_addr,
    output logic                              cap_clear,
    output logic                              txd,
    output logic                              tx_busy
);

    playback_pkg::ctrl_state_t state;
    playback_pkg::ctrl_state_t state_nxt;

    logic [playback_pkg::MSG_AW:0]   msg_ptr;  // extra bit marks the end of the ROM
    logic [playback_pkg::CNT_W-1:0]  cap_ptr;
    logic                            tx_send;
    logic [playback_pkg::DATA_W-1:0] tx_data;
    logic                            msg_end;

    assign msg_addr = msg_ptr[playback_pkg::MSG_AW-1:0];
    assign cap_addr = cap_ptr[playback_pkg::CAP_AW-1:0];
    assign msg_end  = (msg_ptr == (playback_pkg::MSG_AW + 1)'(playback_pkg::MSG_DEPTH));
    assign tx_data  = (state == playback_pkg::CAP_READ) ? cap_byte : msg_byte;

    uart_tx u_tx (
        .CLK100MHZ (CLK100MHZ),
        .rst       (rst),
        .tx_send   (tx_send),
        .tx_data   (tx_data),
        .txd       (txd),
        .tx_busy   (tx_busy)
    );

    always_comb begin
        state_nxt = state;
        tx_send   = 1'b0;
        case (state)
            playback_pkg::IDLE: begin
                if (play_msg) begin
                    state_nxt = playback_pkg::MSG_READ;  // message has priority
                end else if (play_capture) begin
                    state_nxt = playback_pkg::CAP_READ;
                end
            end
            playback_pkg::MSG_READ: begin
                if (msg_byte == playback_pkg::STOP_CHAR) begin
                    state_nxt = playback_pkg::DONE;
                end else if (!tx_busy) begin
                    tx_send   = 1'b1;
                    state_nxt = playback_pkg::MSG_SEND;
                end
            end
            playback_pkg::MSG_SEND: begin
                if (!tx_busy) begin
                    state_nxt = msg_end ? playback_pkg::DONE : playback_pkg::MSG_READ;
                end
            end
            playback_pkg::CAP_READ: begin
                if (cap_ptr == cap_count) begin
                    state_nxt = playback_pkg::DONE;  // also covers an empty buffer
                end else if (!tx_busy) begin
                    tx_send   = 1'b1;
                    state_nxt = playback_pkg::CAP_SEND;
                end
            end
            playback_pkg::CAP_SEND: begin
                if (!tx_busy) begin
                    state_nxt = playback_pkg::CAP_READ;
                end
            end
            playback_pkg::DONE: state_nxt = playback_pkg::IDLE;
            default:            state_nxt = playback_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            state     <= playback_pkg::IDLE;
            msg_ptr   <= '0;
            cap_ptr   <= '0;
            cap_clear <= 1'b0;
        end else begin
            state <= state_nxt;
            // high during DONE only after a capture replay
            cap_clear <= (state == playback_pkg::CAP_READ) && (state_nxt == playback_pkg::DONE);
            if (state == playback_pkg::DONE) begin
                msg_ptr <= '0;
                cap_ptr <= '0;
            end else if (tx_send && state == playback_pkg::MSG_READ) begin
                msg_ptr <= msg_ptr + 1'b1;  // next read runs while this byte shifts out
            end else if (tx_send && state == playback_pkg::CAP_READ) begin
                cap_ptr <= cap_ptr + 1'b1;
            end
        end
    end

endmodule

/* capture_buffer.sv */
// capture buffer
// receives bytes from the serial line and stores them in arrival order,
// keeps the byte count and serves a separate registered read port
`timescale 1ns/1ps

module capture_buffer (
    input  logic                              CLK100MHZ,
    input  logic                              rst,
    input  logic                              rxd,
    input  logic [playback_pkg::CAP_AW-1:0]   cap_addr,
    input  logic                              cap_clear,
    output logic [playback_pkg::DATA_W-1:0]   cap_byte,
    output logic [playback_pkg::CNT_W-1:0]    cap_count,
    output logic                              rx_busy
);

    logic [playback_pkg::DATA_W-1:0] mem [playback_pkg::CAP_DEPTH];
    logic [playback_pkg::DATA_W-1:0] rx_byte;
    logic                            rx_strobe;
    logic [playback_pkg::CAP_AW-1:0] wr_ptr;
    logic                            full;
    logic                            wr_en;

    uart_rx u_rx (
        .CLK100MHZ (CLK100MHZ),
        .rst       (rst),
        .rxd       (rxd),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .rx_busy   (rx_busy)
    );

    assign full  = (cap_count == playback_pkg::CNT_W'(playback_pkg::CAP_DEPTH));
    assign wr_en = rx_strobe && !full && !cap_clear;  // clear wins over a write

    always_ff @(posedge CLK100MHZ) begin
        if (rst || cap_clear) begin
            wr_ptr    <= '0;
            cap_count <= '0;
        end else if (wr_en) begin
            wr_ptr    <= wr_ptr + 1'b1;
            cap_count <= cap_count + 1'b1;
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (wr_en) begin
            mem[wr_ptr] <= rx_byte;
        end
        cap_byte <= mem[cap_addr];  // replay side
    end

endmodule

/* message_rom.sv */
// message memory
// registered-read ROM holding the text to play back,
// loaded from message.hex at start-up
`timescale 1ns/1ps

module message_rom (
    input  logic                              CLK100MHZ,
    input  logic [playback_pkg::MSG_AW-1:0]   msg_addr,
    output logic [playback_pkg::DATA_W-1:0]   msg_byte
);

    logic [playback_pkg::DATA_W-1:0] mem [playback_pkg::MSG_DEPTH];

    initial begin
        // entries past the end of the file read as stop
        for (int i = 0; i < playback_pkg::MSG_DEPTH; i++) begin
            mem[i] = playback_pkg::STOP_CHAR;
        end
        $readmemh("message.hex", mem);
    end

    always_ff @(posedge CLK100MHZ) begin
        msg_byte <= mem[msg_addr];  // one cycle read latency
    end

endmodule

/* uart_tx.sv */
// serial transmitter
// frames one byte as start bit, 8 data bits lsb first and stop bit,
// each held for one bit time
`timescale 1ns/1ps

module uart_tx (
    input  logic                              CLK100MHZ,
    input  logic                              rst,
    input  logic                              tx_send,
    input  logic [playback_pkg::DATA_W-1:0]   tx_data,
    output logic                              txd,
    output logic                              tx_busy
);

    logic [playback_pkg::FRAME_BITS-1:0]         frame;    // shifts out from bit 0
    logic [playback_pkg::CLK_CNT_W-1:0]          clk_cnt;
    logic [$clog2(playback_pkg::FRAME_BITS)-1:0] bit_cnt;
    logic                                        bit_end;

    assign bit_end = (clk_cnt == playback_pkg::CLK_CNT_W'(playback_pkg::CLKS_PER_BIT - 1));

    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (tx_send) begin
                tx_busy <= 1'b1;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == playback_pkg::FRAME_BITS - 1) begin
                tx_busy <= 1'b0;  // stop bit done
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (tx_send && !tx_busy) begin
            frame <= {1'b1, tx_data, 1'b0};
        end else if (tx_busy && bit_end) begin
            frame <= {1'b1, frame[playback_pkg::FRAME_BITS-1:1]};
        end
    end

    assign txd = tx_busy ? frame[0] : 1'b1;  // line idles high

endmodule

/* uart_rx.sv */
// serial receiver
// synchronises the line, finds the start bit, samples 8 data bits
// lsb first at the bit centres and strobes out bytes with a good stop bit
`timescale 1ns/1ps

module uart_rx (
    input  logic                              CLK100MHZ,
    input  logic                              rst,
    input  logic                              rxd,
    output logic [playback_pkg::DATA_W-1:0]   rx_byte,
    output logic                              rx_strobe,
    output logic                              rx_busy
);

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;                                          // for edge detect
    logic [playback_pkg::CLK_CNT_W-1:0]        clk_cnt;
    logic [$clog2(playback_pkg::DATA_W+3)-1:0] bit_idx;   // 0 start, 9 stop, 10 tail
    logic [playback_pkg::DATA_W-1:0]           shift;
    logic                                      bit_end;

    assign bit_end = (clk_cnt == playback_pkg::CLK_CNT_W'(playback_pkg::CLKS_PER_BIT - 1));

    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            rx_meta <= 1'b1;  // idle line is high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            rx_busy   <= 1'b0;
            rx_strobe <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
        end else begin
            rx_strobe <= 1'b0;
            if (!rx_busy) begin
                if (rx_prev && !rx_sync) begin
                    rx_busy <= 1'b1;
                    bit_idx <= '0;
                    // first sample lands half a bit in
                    clk_cnt <= playback_pkg::CLK_CNT_W'(playback_pkg::CLKS_PER_BIT / 2);
                end
            end else if (bit_end) begin
                clk_cnt <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 0 && rx_sync) begin
                    rx_busy <= 1'b0;  // line back high so no start bit
                end else if (bit_idx == playback_pkg::DATA_W + 1) begin
                    rx_strobe <= rx_sync;  // framing error drops the byte
                    clk_cnt   <= playback_pkg::CLK_CNT_W'(playback_pkg::CLKS_PER_BIT / 2);
                end else if (bit_idx == playback_pkg::DATA_W + 2) begin
                    rx_busy <= 1'b0;  // end of stop bit
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // data path, shifts in lsb first
    always_ff @(posedge CLK100MHZ) begin
        if (rx_busy && bit_end && bit_idx != 0 && bit_idx <= playback_pkg::DATA_W) begin
            shift <= {rx_sync, shift[playback_pkg::DATA_W-1:1]};
        end
        if (rx_busy && bit_end && bit_idx == playback_pkg::DATA_W + 1) begin
            rx_byte <= shift;
        end
    end

endmodule

/* playback_pkg.sv */
// text playback shared definitions
// byte width, memory sizes, serial bit timing, the stop character
// and the playback controller states
package playback_pkg;

    // serial byte and frame
    localparam int DATA_W       = 8;
    localparam int CLKS_PER_BIT = 16;            // kept small for simulation
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int FRAME_BITS   = DATA_W + 2;    // start, data, stop

    // message memory
    localparam int MSG_DEPTH = 64;
    localparam int MSG_AW    = 6;

    // capture buffer
    localparam int CAP_DEPTH = 256;
    localparam int CAP_AW    = 8;
    localparam int CNT_W     = CAP_AW + 1;       // room for a full count of 256

    // end of message marker
    localparam logic [DATA_W-1:0] STOP_CHAR = 8'h04;

    // playback controller states
    typedef enum logic [2:0] {
        IDLE,
        MSG_READ,    // message byte on the ROM output
        MSG_SEND,    // message byte going out
        CAP_READ,    // captured byte on the buffer output
        CAP_SEND,    // captured byte going out
        DONE
    } ctrl_state_t;

endpackage
